//--- design/mm2s_pkg.sv
`default_nettype none

package mm2s_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int pixel_width     = 8;
	localparam int data_width      = 32;
	localparam int pixels_per_word = data_width / pixel_width;
	localparam int addr_width      = 32;
	localparam int img_wbits       = 12;
	localparam int img_hbits       = 12;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [pixel_width-1:0] pixel_t;

	// One lane FIFO entry, also one stream beat
	typedef struct packed {
		pixel_t pixel;
		logic   sof;   // tuser, first pixel of frame
		logic   eol;   // tlast, last pixel of line
	} pixel_entry_t;

	// Read address, len is beats minus one
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [7:0]            len;
	} axi_ar_t;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic                  last;
	} axi_r_t;

	typedef struct packed {
		logic [img_wbits-1:0] width;    // pixels
		logic [img_hbits-1:0] height;   // lines
	} img_size_t;

	// Index 0 is leftmost pixel, from the top byte of the beat
	typedef pixel_entry_t [pixels_per_word-1:0] lane_vec_t;

endpackage

`default_nettype wire

//--- design/frame_reader.sv
`default_nettype none

module frame_reader #(
	parameter int burst_len = 4
) (
	input  wire                                 f2s_aclk,
	input  wire                                 resetn,
	input  wire                                 fsync,
	input  wire [mm2s_pkg::addr_width-1:0]      base_addr,
	input  wire mm2s_pkg::img_size_t            img_size,
	output logic                                frame_start,
	output mm2s_pkg::axi_ar_t                   ar,
	output logic                                arvalid,
	input  wire                                 arready,
	input  wire mm2s_pkg::axi_r_t               r,
	input  wire                                 rvalid,
	output logic                                rready,
	input  wire [mm2s_pkg::pixels_per_word-1:0] lane_full,
	output logic                                wr_en,
	output mm2s_pkg::lane_vec_t                 wr_lanes
);
	import mm2s_pkg::*;

	localparam int word_bytes = data_width / 8;
	localparam int word_shift = $clog2(pixels_per_word);

	typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

	state_t               state;
	logic [addr_width-1:0] cur_addr;
	logic [img_wbits-1:0] line_words;
	logic [img_wbits-1:0] words_left;
	logic [img_hbits-1:0] lines_left;
	logic                 sof_pend;
	logic [img_wbits-1:0] burst_words;
	logic                 beat;
	logic                 line_end;
	logic                 frame_end;

	////////////////////////////////////////////////////////////////////////////
	// Burst request
	////////////////////////////////////////////////////////////////////////////

	// Burst clipped at line end
	always_comb begin
		if (words_left > img_wbits'(burst_len)) begin
			burst_words = img_wbits'(burst_len);
		end else begin
			burst_words = words_left;
		end
	end

	// Counters frozen in st_addr, so ar holds until arready
	assign ar.addr = cur_addr;
	assign ar.len  = 8'(burst_words - 1'b1);

	////////////////////////////////////////////////////////////////////////////
	// Data beats
	////////////////////////////////////////////////////////////////////////////

	// Stall whole beat if any lane is full
	assign rready    = (state == st_data) & ~(|lane_full);
	assign beat      = rvalid & rready;
	assign line_end  = (words_left == img_wbits'(1));
	assign frame_end = line_end & (lines_left == '0);
	assign wr_en     = beat;

	// Top byte goes to lane 0
	always_comb begin
		for (int i = 0; i < pixels_per_word; i++) begin
			wr_lanes[i].pixel = r.data[data_width-1-i*pixel_width -: pixel_width];
			wr_lanes[i].sof   = sof_pend & (i == 0);
			wr_lanes[i].eol   = line_end & (i == pixels_per_word-1);
		end
	end

	// FSM
	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			state       <= st_idle;
			arvalid     <= 1'b0;
			frame_start <= 1'b0;
			sof_pend    <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			case (state)
				st_idle: begin
					// fsync only taken here
					if (fsync) begin
						state       <= st_addr;
						arvalid     <= 1'b1;
						frame_start <= 1'b1;
						sof_pend    <= 1'b1;
					end
				end
				st_addr: begin
					if (arready) begin
						state   <= st_data;
						arvalid <= 1'b0;
					end
				end
				default: begin
					if (beat && frame_end) begin
						state <= st_idle;
					end else if (beat && r.last) begin
						state   <= st_addr;
						arvalid <= 1'b1;
					end
				end
			endcase
			if (beat) sof_pend <= 1'b0;
		end
	end

	// Frame walk counters, loaded on accepted fsync
	always_ff @(posedge f2s_aclk) begin
		if (state == st_idle && fsync) begin
			cur_addr   <= base_addr;
			line_words <= img_size.width >> word_shift;
			words_left <= img_size.width >> word_shift;
			lines_left <= img_size.height - 1'b1;
		end else if (beat) begin
			cur_addr <= cur_addr + addr_width'(word_bytes);
			if (line_end) begin
				words_left <= line_words;
				lines_left <= lines_left - 1'b1;
			end else begin
				words_left <= words_left - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/lane_fifo.sv
`default_nettype none

module lane_fifo #(
	parameter int lane_depth = 8
) (
	input  wire                         f2s_aclk,
	input  wire                         resetn,
	input  wire                         wr_en,
	input  wire mm2s_pkg::pixel_entry_t wr_entry,
	input  wire                         rd_en,
	output mm2s_pkg::pixel_entry_t      rd_entry,
	output logic                        full,
	output logic                        empty
);
	import mm2s_pkg::*;

	localparam int ptr_w = $clog2(lane_depth);

	pixel_entry_t     mem [lane_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;
	logic             wr_ok;
	logic             rd_ok;

	// Overflow and underflow dropped
	assign wr_ok = wr_en & ~full;
	assign rd_ok = rd_en & ~empty;

	assign full     = (count == (ptr_w+1)'(lane_depth));
	assign empty    = (count == '0);
	// Head seen the cycle after write
	assign rd_entry = mem[rd_ptr];

	always_ff @(posedge f2s_aclk) begin
		if (wr_ok) mem[wr_ptr] <= wr_entry;
	end

	// Pointers wrap, depth a power of two
	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/stream_out.sv
`default_nettype none

module stream_out (
	input  wire                                 f2s_aclk,
	input  wire                                 resetn,
	input  wire [mm2s_pkg::pixels_per_word-1:0] lane_empty,
	input  wire mm2s_pkg::lane_vec_t            lane_head,
	input  wire                                 m_axis_tready,
	output logic [mm2s_pkg::pixels_per_word-1:0] lane_rd,
	output mm2s_pkg::pixel_entry_t              m_axis,
	output logic                                m_axis_tvalid
);
	import mm2s_pkg::*;

	localparam int lane_w = $clog2(pixels_per_word);

	logic [lane_w-1:0] lane_ptr;
	logic              rd_go;

	////////////////////////////////////////////////////////////////////////////
	// Lane select
	////////////////////////////////////////////////////////////////////////////

	// Output reg free or draining, current lane has data
	assign rd_go = ~lane_empty[lane_ptr] & (~m_axis_tvalid | m_axis_tready);

	// One-hot pop of the current lane
	always_comb begin
		lane_rd           = '0;
		lane_rd[lane_ptr] = rd_go;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge f2s_aclk) begin
		if (!resetn) begin
			m_axis_tvalid <= 1'b0;
			lane_ptr      <= '0;
		end else if (rd_go) begin
			m_axis_tvalid <= 1'b1;
			// Next lane in pixel order
			if (lane_ptr == lane_w'(pixels_per_word-1)) begin
				lane_ptr <= '0;
			end else begin
				lane_ptr <= lane_ptr + 1'b1;
			end
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
		end
	end

	// Beat payload, held while stalled
	always_ff @(posedge f2s_aclk) begin
		if (rd_go) m_axis <= lane_head[lane_ptr];
	end

endmodule

`default_nettype wire

//--- design/mm2s_top.sv
`default_nettype none

module mm2s_top #(
	parameter int burst_len  = 4,
	parameter int lane_depth = 8
) (
	input  wire                            f2s_aclk,
	input  wire                            resetn,
	// Frame control
	input  wire                            fsync,
	input  wire [mm2s_pkg::addr_width-1:0] base_addr,
	input  wire mm2s_pkg::img_size_t       img_size,
	output wire                            frame_start,
	// AXI read
	output wire mm2s_pkg::axi_ar_t         ar,
	output wire                            arvalid,
	input  wire                            arready,
	input  wire mm2s_pkg::axi_r_t          r,
	input  wire                            rvalid,
	output wire                            rready,
	// AXI-Stream out
	output wire mm2s_pkg::pixel_entry_t    m_axis,
	output wire                            m_axis_tvalid,
	input  wire                            m_axis_tready
);
	import mm2s_pkg::*;

	wire                       wr_en;
	wire lane_vec_t            wr_lanes;
	wire lane_vec_t            lane_head;
	wire [pixels_per_word-1:0] lane_full;
	wire [pixels_per_word-1:0] lane_empty;
	wire [pixels_per_word-1:0] lane_rd;

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////////////

	frame_reader #(
		.burst_len(burst_len)
	) u_reader (
		.f2s_aclk    (f2s_aclk),
		.resetn      (resetn),
		.fsync       (fsync),
		.base_addr   (base_addr),
		.img_size    (img_size),
		.frame_start (frame_start),
		.ar          (ar),
		.arvalid     (arvalid),
		.arready     (arready),
		.r           (r),
		.rvalid      (rvalid),
		.rready      (rready),
		.lane_full   (lane_full),
		.wr_en       (wr_en),
		.wr_lanes    (wr_lanes)
	);

	// One FIFO per pixel lane, all written together
	for (genvar i = 0; i < pixels_per_word; i++) begin : g_lane
		lane_fifo #(
			.lane_depth(lane_depth)
		) u_fifo (
			.f2s_aclk (f2s_aclk),
			.resetn   (resetn),
			.wr_en    (wr_en),
			.wr_entry (wr_lanes[i]),
			.rd_en    (lane_rd[i]),
			.rd_entry (lane_head[i]),
			.full     (lane_full[i]),
			.empty    (lane_empty[i])
		);
	end

	stream_out u_stream (
		.f2s_aclk      (f2s_aclk),
		.resetn        (resetn),
		.lane_empty    (lane_empty),
		.lane_head     (lane_head),
		.m_axis_tready (m_axis_tready),
		.lane_rd       (lane_rd),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid)
	);

endmodule

`default_nettype wire

//--- tb/mm2s_asserts.sv
`default_nettype none

module mm2s_asserts (
	input wire                                 f2s_aclk,
	input wire                                 resetn,
	input wire mm2s_pkg::axi_ar_t              ar,
	input wire                                 arvalid,
	input wire                                 arready,
	input wire                                 rready,
	input wire [mm2s_pkg::pixels_per_word-1:0] lane_full,
	input wire                                 frame_start,
	input wire mm2s_pkg::pixel_entry_t         m_axis,
	input wire                                 m_axis_tvalid,
	input wire                                 m_axis_tready
);
	timeunit 1ns;
	timeprecision 1ps;
	import mm2s_pkg::*;

	// Failures seen, summed by the testbench
	int fails = 0;

	////////////////////////////////////////////////////////////////////////////
	// Protocol rules
	////////////////////////////////////////////////////////////////////////////

	// AR held until accepted
	ar_hold: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(ar))
	else begin
		$error("ar or arvalid changed before arready");
		fails++;
	end

	// Stream beat held under stall
	axis_hold: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
	else begin
		$error("m_axis or tvalid changed while tready low");
		fails++;
	end

	frame_start_pulse: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		frame_start |=> !frame_start)
	else begin
		$error("frame_start longer than one cycle");
		fails++;
	end

	no_read_when_full: assert property (@(posedge f2s_aclk) disable iff (!resetn)
		|lane_full |-> !rready)
	else begin
		$error("rready high with a full lane");
		fails++;
	end

endmodule

bind mm2s_top mm2s_asserts u_asserts (
	.f2s_aclk      (f2s_aclk),
	.resetn        (resetn),
	.ar            (ar),
	.arvalid       (arvalid),
	.arready       (arready),
	.rready        (rready),
	.lane_full     (lane_full),
	.frame_start   (frame_start),
	.m_axis        (m_axis),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tready (m_axis_tready)
);

`default_nettype wire

//--- tb/tb_mm2s.sv
`default_nettype none

module tb_mm2s;
	timeunit 1ns;
	timeprecision 1ps;
	import mm2s_pkg::*;

	localparam int burst_len  = 4;
	localparam int lane_depth = 8;
	// About 460 pixels over all tests, under 40 cycles each even with stalls
	localparam int max_cycles = 20000;
	// Quiet time after a drain, long enough for a stray burst to show
	localparam int settle_cycles = 32;

	logic                  f2s_aclk = 1'b0;
	logic                  resetn = 1'b0;
	logic                  fsync = 1'b0;
	logic [addr_width-1:0] base_addr = '0;
	img_size_t             img_size = '0;
	logic                  frame_start;
	axi_ar_t               ar;
	logic                  arvalid;
	logic                  arready = 1'b0;
	axi_r_t                r = '0;
	logic                  rvalid = 1'b0;
	logic                  rready;
	pixel_entry_t          m_axis;
	logic                  m_axis_tvalid;
	logic                  m_axis_tready = 1'b0;

	// Scoreboard
	pixel_entry_t          exp_px[$];
	axi_ar_t               exp_ar[$];
	axi_ar_t               ar_log[$];
	int                    errors = 0;
	int                    checks = 0;
	int                    tests = 0;
	int                    rx_count = 0;
	int                    fs_count = 0;
	int                    cycles = 0;
	logic                  bp_mode = 1'b0;

	// Memory model state
	integer                seed = 32'h63dea59f;
	logic                  in_burst = 1'b0;
	logic [addr_width-1:0] rd_addr = '0;
	int                    beats_left = 0;
	int                    ar_gap = 0;
	int                    beats_served = 0;

	mm2s_top #(
		.burst_len  (burst_len),
		.lane_depth (lane_depth)
	) u_dut (
		.f2s_aclk      (f2s_aclk),
		.resetn        (resetn),
		.fsync         (fsync),
		.base_addr     (base_addr),
		.img_size      (img_size),
		.frame_start   (frame_start),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready),
		.r             (r),
		.rvalid        (rvalid),
		.rready        (rready),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	initial begin
		forever #2 f2s_aclk = ~f2s_aclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	// Byte content mixes every address byte
	function automatic pixel_t mem_byte(input logic [addr_width-1:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ a[31:24] ^ 8'ha5;
	endfunction

	// Lower address lands in the top byte
	function automatic axi_r_t make_beat(input logic [addr_width-1:0] a, input logic last);
		axi_r_t b;
		b.data = '0;
		for (int i = 0; i < pixels_per_word; i++) begin
			b.data = (b.data << pixel_width) | data_width'(mem_byte(a + i));
		end
		b.last = last;
		return b;
	endfunction

	function automatic int roll(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// One burst at a time, random AR gap and rvalid gaps
	always @(posedge f2s_aclk) begin
		if (!resetn) begin
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			in_burst <= 1'b0;
			ar_gap   <= roll(4);
		end else if (!in_burst) begin
			if (arvalid && arready) begin
				arready    <= 1'b0;
				in_burst   <= 1'b1;
				rd_addr    <= ar.addr;
				beats_left <= int'(ar.len) + 1;
				ar_gap     <= roll(4);
				ar_log.push_back(ar);
			end else if (arvalid) begin
				if (ar_gap == 0) begin
					arready <= 1'b1;
				end else begin
					ar_gap <= ar_gap - 1;
				end
			end
		end else if (rvalid && rready) begin
			beats_served <= beats_served + 1;
			if (beats_left == 1) begin
				rvalid   <= 1'b0;
				in_burst <= 1'b0;
			end else begin
				beats_left <= beats_left - 1;
				rd_addr    <= rd_addr + 4;
				r          <= make_beat(rd_addr + 4, beats_left == 2);
				rvalid     <= (roll(4) != 0);
			end
		end else if (!rvalid) begin
			r      <= make_beat(rd_addr, beats_left == 1);
			rvalid <= (roll(4) != 0);
		end
	end

	// Sink, random stalls in back-pressure mode
	always @(posedge f2s_aclk) begin
		if (!resetn) begin
			m_axis_tready <= 1'b0;
		end else begin
			m_axis_tready <= bp_mode ? (roll(2) == 0) : 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_pixel(input pixel_entry_t got);
		pixel_entry_t want;
		checks++;
		rx_count++;
		if (exp_px.size() == 0) begin
			$display("Extra pixel %02h came out at %0t with nothing left to expect",
				got.pixel, $time);
			errors++;
		end else begin
			want = exp_px.pop_front();
			if (got !== want) begin
				$display("FAIL %0t: pixel %0d got %02h sof %b eol %b, want %02h sof %b eol %b",
					$time, rx_count, got.pixel, got.sof, got.eol,
					want.pixel, want.sof, want.eol);
				errors++;
			end
		end
	endtask

	task automatic check_ar(input axi_ar_t got);
		axi_ar_t want;
		checks++;
		want = exp_ar.pop_front();
		if (got !== want) begin
			$display("FAIL %0t: burst addr %08h len %0d, want addr %08h len %0d",
				$time, got.addr, got.len, want.addr, want.len);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int want);
		checks++;
		if (got != want) begin
			$display("FAIL %0t: %s is %0d, want %0d", $time, what, got, want);
			errors++;
		end
	endtask

	// Strobe must read a clean 0, X included
	task automatic check_idle(input string what, input logic got);
		checks++;
		if (got !== 1'b0) begin
			$display("FAIL %0t: %s is %b, want 0", $time, what, got);
			errors++;
		end
	endtask

	always @(posedge f2s_aclk) begin
		if (resetn && m_axis_tvalid && m_axis_tready) check_pixel(m_axis);
		if (resetn && frame_start) fs_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and test helpers
	////////////////////////////////////////////////////////////////////////////

	// Raster order, one line of w bytes after another
	task automatic expect_frame(input logic [addr_width-1:0] base, input int w, input int h);
		pixel_entry_t e;
		axi_ar_t      a;
		int           words;
		int           n;
		words = w / pixels_per_word;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				e.pixel = mem_byte(base + y * w + x);
				e.sof   = (y == 0 && x == 0);
				e.eol   = (x == w - 1);
				exp_px.push_back(e);
			end
			// Bursts never run past the line end
			for (int wd = 0; wd < words; wd += n) begin
				n      = (words - wd > burst_len) ? burst_len : words - wd;
				a.addr = base + y * w + wd * 4;
				a.len  = 8'(n - 1);
				exp_ar.push_back(a);
			end
		end
	endtask

	task automatic start_frame(input logic [addr_width-1:0] base, input int w, input int h);
		base_addr       <= base;
		img_size.width  <= img_wbits'(w);
		img_size.height <= img_hbits'(h);
		fsync           <= 1'b1;
		@(posedge f2s_aclk);
		fsync <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_px.size() != 0) @(posedge f2s_aclk);
	endtask

	// Any stray beat or burst lands in the counts here
	task automatic settle();
		repeat (settle_cycles) @(posedge f2s_aclk);
	endtask

	task automatic verify_bursts();
		check_count("burst count", ar_log.size(), exp_ar.size());
		while (ar_log.size() != 0 && exp_ar.size() != 0) check_ar(ar_log.pop_front());
		ar_log.delete();
		exp_ar.delete();
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		$display("test %-14s done, %0d errors", name, errors - err0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic single_frame();
		int err0;
		int fs0;
		err0 = errors;
		fs0  = fs_count;
		expect_frame(32'h0000_0100, 8, 3);
		start_frame(32'h0000_0100, 8, 3);
		wait_drain();
		verify_bursts();
		check_count("frame_start pulses", fs_count - fs0, 1);
		report_test("single_frame", err0);
	endtask

	// 6 words per line, so bursts of 4 then 2
	task automatic burst_split();
		int err0;
		err0 = errors;
		expect_frame(32'h0000_0400, 24, 2);
		start_frame(32'h0000_0400, 24, 2);
		wait_drain();
		verify_bursts();
		report_test("burst_split", err0);
	endtask

	task automatic back_pressure();
		int err0;
		int rx0;
		err0 = errors;
		rx0  = rx_count;
		bp_mode <= 1'b1;
		expect_frame(32'h0001_0000, 16, 4);
		start_frame(32'h0001_0000, 16, 4);
		wait_drain();
		bp_mode <= 1'b0;
		settle();
		verify_bursts();
		check_count("pixels under stall", rx_count - rx0, 64);
		report_test("back_pressure", err0);
	endtask

	// Second fsync right after the reader has fetched the first frame
	task automatic back_to_back();
		int err0;
		int fs0;
		int target;
		err0 = errors;
		fs0  = fs_count;
		expect_frame(32'h0000_1000, 8, 2);
		expect_frame(32'h0002_0040, 16, 3);
		target = beats_served + 4;
		start_frame(32'h0000_1000, 8, 2);
		while (beats_served < target) @(posedge f2s_aclk);
		start_frame(32'h0002_0040, 16, 3);
		wait_drain();
		verify_bursts();
		check_count("frame_start pulses", fs_count - fs0, 2);
		report_test("back_to_back", err0);
	endtask

	task automatic fsync_ignored();
		int err0;
		int fs0;
		int rx0;
		err0 = errors;
		fs0  = fs_count;
		rx0  = rx_count;
		expect_frame(32'h0000_4000, 32, 8);
		start_frame(32'h0000_4000, 32, 8);
		// Frame is 16 bursts long, so still busy here
		while (ar_log.size() < 2) @(posedge f2s_aclk);
		start_frame(32'h0000_8000, 8, 2);
		wait_drain();
		settle();
		verify_bursts();
		check_count("frame_start pulses", fs_count - fs0, 1);
		check_count("pixels in frame", rx_count - rx0, 256);
		report_test("fsync_ignored", err0);
	endtask

	initial begin : watchdog
		while (cycles < max_cycles) begin
			@(posedge f2s_aclk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		repeat (5) @(posedge f2s_aclk);
		resetn <= 1'b1;
		@(posedge f2s_aclk);
		// Idle outputs straight after reset
		check_idle("arvalid after reset", arvalid);
		check_idle("rready after reset", rready);
		check_idle("frame_start after reset", frame_start);
		check_idle("tvalid after reset", m_axis_tvalid);
		single_frame();
		burst_split();
		back_pressure();
		back_to_back();
		fsync_ignored();
		errors += u_dut.u_asserts.fails;
		$display("Summary: %0d tests, %0d checks, %0d errors, %0d cycles",
			tests, checks, errors, cycles);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/mm2s_pkg.sv
design/frame_reader.sv
design/lane_fifo.sv
design/stream_out.sv
design/mm2s_top.sv
tb/mm2s_asserts.sv
tb/tb_mm2s.sv
